// File: source/adxlPkg.sv
`default_nettype none

package adxlPkg;

    // ************************************************************************
    // SPI instruction codes and the ADXL362 register map
    // ************************************************************************

    localparam logic [7:0] INSTR_WRITE     = 8'h0A;  // register write instruction.
    localparam logic [7:0] INSTR_READ      = 8'h0B;  // register read instruction.

    localparam logic [7:0] ADDR_SOFT_RESET = 8'h1F;  // soft reset register.
    localparam logic [7:0] ADDR_POWER_CTL  = 8'h2D;  // power control register.
    localparam logic [7:0] ADDR_FILTER_CTL = 8'h2C;  // filter control register.
    localparam logic [7:0] ADDR_XDATA      = 8'h08;  // 8-bit x axis data.
    localparam logic [7:0] ADDR_YDATA      = 8'h09;  // 8-bit y axis data.
    localparam logic [7:0] ADDR_ZDATA      = 8'h0A;  // 8-bit z axis data.
    localparam logic [7:0] ADDR_TEMP_L     = 8'h14;  // temperature low byte.
    localparam logic [7:0] ADDR_TEMP_H     = 8'h15;  // temperature high nibble lives here.

    localparam logic [7:0] VAL_SOFT_RESET  = 8'h52;  // the key that triggers a soft reset.
    localparam logic [7:0] VAL_POWER_CTL   = 8'h02;  // measurement mode.
    localparam logic [7:0] VAL_FILTER_CTL  = 8'h14;  // range and output data rate.
    localparam logic [7:0] DUMMY_BYTE      = 8'hFF;  // sent in the data slot of a read.

    // ************************************************************************
    // SPI timing
    // ************************************************************************

    localparam int SCLK_HALF     = 4;  // clk cycles per half SCLK period.
    localparam int BYTES_PER_CMD = 3;  // instruction, address and data byte.

    // one SPI transaction as it goes out on the wire, instruction first.
    typedef struct packed {
        logic [7:0] instruction;
        logic [7:0] address;
        logic [7:0] data;
    } spiCommand;

    // one complete sample as published once per read loop.
    typedef struct packed {
        logic [7:0]  dataX;
        logic [7:0]  dataY;
        logic [7:0]  dataZ;
        logic [11:0] dataT;
    } accelSample;

endpackage

`default_nettype wire

// File: source/spiShifter.sv
`timescale 1ns/1ps
`default_nettype none

module spiShifter (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_byteStart,
    input  logic [7:0] i_byteOut,
    output logic       o_byteDone,
    output logic [7:0] o_byteIn,
    output logic       o_spiClk,
    output logic       o_spiMosi,
    input  logic       i_spiMiso
);
    import adxlPkg::*;

    localparam int DIV_W  = $clog2(SCLK_HALF);  // width of the half period divider.
    localparam int HALVES = 16;                 // eight SCLK periods make one byte.

    logic [DIV_W-1:0] divCnt;   // clk cycles within the current half period.
    logic [3:0]       halfCnt;  // half periods done so far in this byte.
    logic             busy;     // a byte is on the wire.
    logic [7:0]       shiftReg; // MOSI leaves at the top while MISO enters at the bottom.
    logic             halfTick; // the current half period ends in this cycle.

    assign halfTick = busy && (divCnt == DIV_W'(SCLK_HALF - 1));
    assign o_byteIn = shiftReg; // holds the received byte once o_byteDone pulses.

    // ************************************************************************
    // clock divider and SCLK / MOSI generation
    // ************************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            divCnt     <= '0;
            halfCnt    <= '0;
            o_spiClk   <= 1'b0;  // mode 0 idles low.
            o_spiMosi  <= 1'b0;
            o_byteDone <= 1'b0;
        end else begin
            o_byteDone <= 1'b0;  // a single cycle pulse by default.
            if (i_byteStart) begin
                busy      <= 1'b1;
                divCnt    <= DIV_W'(1);     // the start cycle counts as the first one.
                halfCnt   <= '0;
                o_spiMosi <= i_byteOut[7];  // msb is set up before the first rise.
            end else if (busy) begin
                if (halfTick) begin
                    divCnt   <= '0;
                    halfCnt  <= halfCnt + 1'b1;
                    o_spiClk <= ~o_spiClk;
                    if (o_spiClk && (halfCnt != 4'(HALVES - 1))) begin
                        o_spiMosi <= shiftReg[7];  // next bit goes out on the falling edge.
                    end
                    if (halfCnt == 4'(HALVES - 1)) begin
                        busy       <= 1'b0;  // the last falling edge closes the byte.
                        o_byteDone <= 1'b1;
                    end
                end else begin
                    divCnt <= divCnt + 1'b1;
                end
            end
        end
    end

    // the shift register loads each new byte and takes in MISO one bit per rise.
    always_ff @(posedge clk) begin
        if (i_byteStart) begin
            shiftReg <= i_byteOut;
        end else if (halfTick && !o_spiClk) begin
            shiftReg <= {shiftReg[6:0], i_spiMiso};  // sample MISO on the rising edge.
        end
    end

endmodule

`default_nettype wire

// File: source/spiTransaction.sv
`timescale 1ns/1ps
`default_nettype none

module spiTransaction (
    input  logic              clk,
    input  logic              reset,
    input  adxlPkg::spiCommand i_cmd,
    input  logic              i_cmdValid,
    output logic              o_cmdReady,
    output logic              o_done,
    output logic [7:0]        o_readData,
    output logic              o_spiCsLow,
    output logic              o_spiClk,
    output logic              o_spiMosi,
    input  logic              i_spiMiso
);
    import adxlPkg::*;

    localparam int DIV_W = $clog2(SCLK_HALF);
    localparam int CNT_W = $clog2(BYTES_PER_CMD);

    typedef enum logic [2:0] {
        ST_IDLE,   // waiting for a command.
        ST_SETUP,  // chip select active before the first SCLK.
        ST_BYTE,   // bytes going out back to back.
        ST_HOLD,   // chip select held after the last SCLK.
        ST_GAP     // chip select high before the next command.
    } txState;

    txState           state;
    logic [DIV_W-1:0] waitCnt;    // cycles spent in setup, hold or gap.
    logic [CNT_W-1:0] byteCnt;    // index of the byte on the wire.
    spiCommand        cmdReg;     // the accepted command.
    logic             accept;     // valid and ready meet in this cycle.
    logic             waitDone;   // the current wait period ends in this cycle.
    logic             lastByte;   // the byte on the wire is the data slot.
    logic             byteStart;
    logic             byteDone;
    logic [7:0]       byteOut;
    logic [7:0]       byteIn;

    assign o_cmdReady = (state == ST_IDLE);
    assign accept     = i_cmdValid && o_cmdReady;
    assign waitDone   = (waitCnt == DIV_W'(SCLK_HALF - 1));
    assign lastByte   = (byteCnt == CNT_W'(BYTES_PER_CMD - 1));

    // byte counter and start pulse change on the same edge so the mux is ready in time.
    always_comb begin
        if (byteCnt == '0) begin
            byteOut = cmdReg.instruction;
        end else if (lastByte) begin
            byteOut = cmdReg.data;
        end else begin
            byteOut = cmdReg.address;
        end
    end

    // ************************************************************************
    // transaction state machine
    // ************************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            waitCnt    <= '0;
            byteCnt    <= '0;
            byteStart  <= 1'b0;
            o_done     <= 1'b0;
            o_spiCsLow <= 1'b0;
        end else begin
            byteStart <= 1'b0;
            o_done    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state      <= ST_SETUP;
                        waitCnt    <= '0;
                        byteCnt    <= '0;
                        o_spiCsLow <= 1'b1;  // select the chip right after acceptance.
                    end
                end
                ST_SETUP: begin
                    if (waitDone) begin
                        state     <= ST_BYTE;
                        byteStart <= 1'b1;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                ST_BYTE: begin
                    if (byteDone && lastByte) begin
                        state   <= ST_HOLD;
                        waitCnt <= DIV_W'(1);  // the byteDone cycle counts toward the hold.
                    end else if (byteDone) begin
                        byteCnt   <= byteCnt + 1'b1;
                        byteStart <= 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (waitDone) begin
                        state      <= ST_GAP;
                        waitCnt    <= '0;
                        o_spiCsLow <= 1'b0;
                        o_done     <= 1'b1;  // done lines up with the release.
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                default: begin
                    if (waitDone) begin
                        state <= ST_IDLE;  // the minimum chip select high time has passed.
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmdReg <= i_cmd;
        end
        if ((state == ST_BYTE) && byteDone && lastByte) begin
            o_readData <= byteIn;  // only the data slot carries register contents.
        end
    end

    spiShifter shifter0 (
        .clk        (clk),
        .reset      (reset),
        .i_byteStart(byteStart),
        .i_byteOut  (byteOut),
        .o_byteDone (byteDone),
        .o_byteIn   (byteIn),
        .o_spiClk   (o_spiClk),
        .o_spiMosi  (o_spiMosi),
        .i_spiMiso  (i_spiMiso)
    );

endmodule

`default_nettype wire

// File: source/adxlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module adxlSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_enable,
    output adxlPkg::spiCommand  o_cmd,
    output logic               o_cmdValid,
    input  logic               i_cmdReady,
    input  logic               i_done,
    input  logic [7:0]         i_readData,
    output adxlPkg::accelSample o_sample,
    output logic               o_sampleValid
);
    import adxlPkg::*;

    typedef enum logic [3:0] {
        SQ_IDLE,
        SQ_SOFT_RESET,
        SQ_POWER_CTL,
        SQ_FILTER_CTL,
        SQ_READ_X,
        SQ_READ_Y,
        SQ_READ_Z,
        SQ_READ_TL,
        SQ_READ_TH
    } seqState;

    seqState    state;
    seqState    nextState;  // where i_done takes the sequencer.
    logic       pending;    // a command was accepted and its done is outstanding.
    logic       isCommand;  // the current state issues a transaction.
    accelSample shadow;     // collects one loop of read results.

    assign isCommand = (state != SQ_IDLE);

    // ************************************************************************
    // command selection and next state
    // ************************************************************************

    always_comb begin
        o_cmd.instruction = INSTR_READ;  // reads are the common case.
        o_cmd.address     = ADDR_XDATA;
        o_cmd.data        = DUMMY_BYTE;
        nextState         = state;
        case (state)
            SQ_SOFT_RESET: begin
                o_cmd.instruction = INSTR_WRITE;
                o_cmd.address     = ADDR_SOFT_RESET;
                o_cmd.data        = VAL_SOFT_RESET;
                nextState         = SQ_POWER_CTL;
            end
            SQ_POWER_CTL: begin
                o_cmd.instruction = INSTR_WRITE;
                o_cmd.address     = ADDR_POWER_CTL;
                o_cmd.data        = VAL_POWER_CTL;
                nextState         = SQ_FILTER_CTL;
            end
            SQ_FILTER_CTL: begin
                o_cmd.instruction = INSTR_WRITE;
                o_cmd.address     = ADDR_FILTER_CTL;
                o_cmd.data        = VAL_FILTER_CTL;
                nextState         = SQ_READ_X;  // start-up is over.
            end
            SQ_READ_X:  nextState = SQ_READ_Y;
            SQ_READ_Y: begin
                o_cmd.address = ADDR_YDATA;
                nextState     = SQ_READ_Z;
            end
            SQ_READ_Z: begin
                o_cmd.address = ADDR_ZDATA;
                nextState     = SQ_READ_TL;
            end
            SQ_READ_TL: begin
                o_cmd.address = ADDR_TEMP_L;
                nextState     = SQ_READ_TH;
            end
            SQ_READ_TH: begin
                o_cmd.address = ADDR_TEMP_H;
                nextState     = SQ_READ_X;  // loop forever over the data registers.
            end
            default: nextState = SQ_IDLE;  // idle leaves through i_enable below.
        endcase
    end

    // ************************************************************************
    // handshake and state register
    // ************************************************************************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SQ_IDLE;
            pending    <= 1'b0;
            o_cmdValid <= 1'b0;
        end else begin
            if (state == SQ_IDLE) begin
                if (i_enable) begin
                    state <= SQ_SOFT_RESET;
                end
            end else if (i_done) begin
                state   <= nextState;
                pending <= 1'b0;  // the next command may be raised a cycle later.
            end
            if (o_cmdValid && i_cmdReady) begin
                o_cmdValid <= 1'b0;
                pending    <= 1'b1;
            end else if (isCommand && !pending && !o_cmdValid && i_enable) begin
                o_cmdValid <= 1'b1;  // held until the engine accepts it.
            end
        end
    end

    // ************************************************************************
    // sample assembly
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (i_done) begin
            case (state)
                SQ_READ_X:  shadow.dataX <= i_readData;
                SQ_READ_Y:  shadow.dataY <= i_readData;
                SQ_READ_Z:  shadow.dataZ <= i_readData;
                SQ_READ_TL: shadow.dataT <= {4'h0, i_readData};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_sample      <= '0;
            o_sampleValid <= 1'b0;
        end else begin
            o_sampleValid <= 1'b0;
            if (i_done && (state == SQ_READ_TH)) begin
                o_sample.dataX <= shadow.dataX;  // all fields come from the same loop.
                o_sample.dataY <= shadow.dataY;
                o_sample.dataZ <= shadow.dataZ;
                o_sample.dataT <= {i_readData[3:0], shadow.dataT[7:0]};
                o_sampleValid  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/adxlTop.sv
`timescale 1ns/1ps
`default_nettype none

module adxlTop (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_enable,
    input  logic               i_spiMiso,
    output logic               o_spiClk,
    output logic               o_spiMosi,
    output logic               o_spiCsLow,
    output adxlPkg::accelSample o_sample,
    output logic               o_sampleValid
);
    import adxlPkg::*;

    spiCommand  cmd;       // the command the sequencer offers.
    logic       cmdValid;
    logic       cmdReady;
    logic       done;      // end of one chip select period.
    logic [7:0] readData;  // data slot of the last transaction.

    adxlSequencer sequencer0 (
        .clk          (clk),
        .reset        (reset),
        .i_enable     (i_enable),
        .o_cmd        (cmd),
        .o_cmdValid   (cmdValid),
        .i_cmdReady   (cmdReady),
        .i_done       (done),
        .i_readData   (readData),
        .o_sample     (o_sample),
        .o_sampleValid(o_sampleValid)
    );

    spiTransaction transaction0 (
        .clk       (clk),
        .reset     (reset),
        .i_cmd     (cmd),
        .i_cmdValid(cmdValid),
        .o_cmdReady(cmdReady),
        .o_done    (done),
        .o_readData(readData),
        .o_spiCsLow(o_spiCsLow),
        .o_spiClk  (o_spiClk),
        .o_spiMosi (o_spiMosi),
        .i_spiMiso (i_spiMiso)
    );

endmodule

`default_nettype wire

// File: bench/adxlSensorModel.sv
`timescale 1ns/1ps
`default_nettype none

module adxlSensorModel (
    input  logic i_spiClk,
    input  logic i_spiMosi,
    input  logic i_spiCsLow,
    output logic o_spiMiso
);
    import adxlPkg::*;

    localparam int LOG_DEPTH = 1024;  // far more transactions than one run produces.

    logic [7:0]  regFile  [64];         // register contents as the bus sees them.
    logic [7:0]  snapshot [64];         // register contents of the loop that just ended.
    spiCommand   txnLog   [LOG_DEPTH];  // every transaction, in the order it arrived.
    logic [15:0] writeLog [LOG_DEPTH];  // address above value for each write.
    int          txnCount;
    int          writeCount;
    int          badInstrCount;   // transactions with an unknown instruction byte.
    int          badLengthCount;  // transactions that were not exactly 24 bits long.
    int          seed;
    int          bitCnt;          // rising SCLK edges seen in this transaction.
    logic [7:0]  rxShift;
    logic [7:0]  txByte;          // register value returned in the data slot.
    spiCommand   rxCmd;

    // new data values for every axis and the temperature.
    task automatic reloadData();
        regFile[6'h08] = 8'($random(seed));
        regFile[6'h09] = 8'($random(seed));
        regFile[6'h0A] = 8'($random(seed));
        regFile[6'h14] = 8'($random(seed));
        regFile[6'h15] = 8'($random(seed));  // the upper nibble is noise the driver drops.
    endtask

    // chip select released, so the command is complete.
    task automatic closeTransaction();
        if (bitCnt != 24) begin
            badLengthCount++;
            $display("sensor model: transaction %0d had %0d bits instead of 24", txnCount, bitCnt);
        end
        if (txnCount < LOG_DEPTH) begin
            txnLog[txnCount] = rxCmd;
        end
        txnCount++;
        if (rxCmd.instruction == INSTR_WRITE) begin
            regFile[rxCmd.address[5:0]] = rxCmd.data;
            if (writeCount < LOG_DEPTH) begin
                writeLog[writeCount] = {rxCmd.address, rxCmd.data};
            end
            writeCount++;
        end else if (rxCmd.instruction == INSTR_READ) begin
            if (rxCmd.address == ADDR_TEMP_H) begin
                snapshot = regFile;  // this loop is over, keep what it read.
                reloadData();
            end
        end else begin
            badInstrCount++;
            $display("sensor model: unknown instruction byte 0x%h", rxCmd.instruction);
        end
    endtask

    initial begin
        seed           = 87;
        txnCount       = 0;
        writeCount     = 0;
        badInstrCount  = 0;
        badLengthCount = 0;
        bitCnt         = 0;
        o_spiMiso      = 1'b0;
        for (int i = 0; i < 64; i++) begin
            regFile[i]  = 8'(i * 7 + 3);  // odd stride keeps every address distinct.
            snapshot[i] = 8'h00;
        end
        reloadData();
    end

    // ************************************************************************
    // SPI mode 0 slave
    // ************************************************************************

    always begin
        @(posedge i_spiCsLow);  // chip select going active opens a transaction.
        bitCnt = 0;
        rxCmd  = '0;
        while (i_spiCsLow) begin
            @(posedge i_spiClk or negedge i_spiCsLow);
            if (i_spiCsLow) begin
                rxShift = {rxShift[6:0], i_spiMosi};  // MOSI is stable at the rising edge.
                bitCnt  = bitCnt + 1;
                case (bitCnt)
                    8:  rxCmd.instruction = rxShift;
                    16: begin
                        rxCmd.address = rxShift;
                        txByte        = regFile[rxShift[5:0]];  // ready before the data slot.
                    end
                    24: rxCmd.data = rxShift;
                    default: ;
                endcase
            end
        end
        closeTransaction();
    end

    always @(negedge i_spiClk) begin
        if (i_spiCsLow && (bitCnt >= 16) && (bitCnt < 24)) begin
            o_spiMiso = txByte[3'(23 - bitCnt)];  // msb goes out right after the address.
        end else begin
            o_spiMiso = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: bench/adxlTopBench.sv
`timescale 1ns/1ps
`default_nettype none

module adxlTopBench;
    import adxlPkg::*;

    localparam int SAMPLES_FIRST  = 20;     // consecutive samples before the pause.
    localparam int SAMPLES_AFTER  = 6;      // samples checked after the resume.
    localparam int SAMPLE_TIMEOUT = 5000;   // one loop takes roughly 1100 cycles.
    localparam int QUIET_CYCLES   = 2000;   // nothing may start during the pause.

    logic       clk;
    logic       reset;
    logic       enable;
    logic       spiMiso;
    logic       spiClk;
    logic       spiMosi;
    logic       spiCsLow;
    accelSample sample;
    logic       sampleValid;
    accelSample expectedNow;    // reference value for the sample being checked.
    int         seed;
    int         valueErrors;
    int         protocolErrors;
    int         timeoutErrors;
    int         sampleCount;
    int         csStarts;       // rising edges of chip select seen so far.
    int         nextTxn;        // first log entry not yet checked once the start-up writes are past.
    logic       csLowLast;

    adxlTop dut0 (
        .clk          (clk),
        .reset        (reset),
        .i_enable     (enable),
        .i_spiMiso    (spiMiso),
        .o_spiClk     (spiClk),
        .o_spiMosi    (spiMosi),
        .o_spiCsLow   (spiCsLow),
        .o_sample     (sample),
        .o_sampleValid(sampleValid)
    );

    adxlSensorModel sensor0 (
        .i_spiClk  (spiClk),
        .i_spiMosi (spiMosi),
        .i_spiCsLow(spiCsLow),
        .o_spiMiso (spiMiso)
    );

    always #5 clk = ~clk;  // 10 ns period.

    // X, Y and Z are plain registers and the temperature takes 12 bits from 15h and 14h.
    function automatic accelSample expectedSample(input logic [7:0] regs [64]);
        accelSample result;
        result.dataX = regs[6'h08];
        result.dataY = regs[6'h09];
        result.dataZ = regs[6'h0A];
        result.dataT = {regs[6'h15][3:0], regs[6'h14]};
        return result;
    endfunction

    task automatic compareField(input string name, input logic [35:0] expected,
                                input logic [35:0] actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("[ERROR] %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic finishRun();
        int total;
        total = valueErrors + protocolErrors + timeoutErrors
              + sensor0.badInstrCount + sensor0.badLengthCount;
        $display("errors: %0d total, %0d value, %0d protocol, %0d timeout, %0d model", total,
                 valueErrors, protocolErrors, timeoutErrors,
                 sensor0.badInstrCount + sensor0.badLengthCount);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic abortOnTimeout(input string what);
        timeoutErrors++;
        $display("timeout at %0t: %s", $time, what);
        finishRun();
    endtask

    task automatic checkIdleOutputs();
        compareField("o_spiCsLow", 36'h0, 36'(spiCsLow));
        compareField("o_spiClk", 36'h0, 36'(spiClk));
        compareField("o_sampleValid", 36'h0, 36'(sampleValid));
        compareField("o_sample", 36'h0, sample);
    endtask

    // exactly five reads of the data registers belong to each sample.
    task automatic checkReadOrder();
        logic [7:0] order [5];
        spiCommand  entry;
        order = '{8'h08, 8'h09, 8'h0A, 8'h14, 8'h15};
        if (sensor0.txnCount - nextTxn != 5) begin
            protocolErrors++;
            $display("expected five reads before sample %0d, saw %0d transactions", sampleCount,
                     sensor0.txnCount - nextTxn);
        end else begin
            for (int k = 0; k < 5; k++) begin
                entry = sensor0.txnLog[nextTxn + k];
                compareField("MOSI instruction byte", 36'h0B, 36'(entry.instruction));
                compareField("MOSI address byte", 36'(order[k]), 36'(entry.address));
                compareField("MOSI data byte", 36'hFF, 36'(entry.data));
            end
        end
        nextTxn = sensor0.txnCount;
    endtask

    task automatic waitForSamples(input int target);
        int idle;
        int seen;
        idle = 0;
        seen = sampleCount;
        while (sampleCount < target) begin
            @(posedge clk);
            if (sampleCount != seen) begin
                seen = sampleCount;
                idle = 0;
            end else begin
                idle++;
                if (idle > SAMPLE_TIMEOUT) begin
                    abortOnTimeout("no o_sampleValid pulse arrived");
                end
            end
        end
    endtask

    // ************************************************************************
    // checking process that samples on the falling edge where outputs are stable
    // ************************************************************************

    always @(negedge clk) begin
        if (!reset) begin
            if (spiCsLow && !csLowLast) begin
                csStarts++;
            end
            csLowLast = spiCsLow;
            if (sampleValid) begin
                expectedNow = expectedSample(sensor0.snapshot);  // taken before the reload.
                compareField("o_sample.dataX", 36'(expectedNow.dataX), 36'(sample.dataX));
                compareField("o_sample.dataY", 36'(expectedNow.dataY), 36'(sample.dataY));
                compareField("o_sample.dataZ", 36'(expectedNow.dataZ), 36'(sample.dataZ));
                compareField("o_sample.dataT", 36'(expectedNow.dataT), 36'(sample.dataT));
                checkReadOrder();
                sampleCount++;
            end
        end
    end

    initial begin
        for (int c = 0; c < 100000; c++) begin
            @(posedge clk);
        end
        abortOnTimeout("the whole run took longer than 100000 cycles");
    end

    // ************************************************************************
    // stimulus
    // ************************************************************************

    initial begin
        int activeCycles;
        int waitCycles;
        int pauseDelay;
        int startsAtDrop;
        int samplesAtQuiet;
        clk            = 1'b0;
        reset          = 1'b1;
        enable         = 1'b0;
        seed           = 87;
        valueErrors    = 0;
        protocolErrors = 0;
        timeoutErrors  = 0;
        sampleCount    = 0;
        csStarts       = 0;
        nextTxn        = 3;  // the three start-up writes come first.
        csLowLast      = 1'b0;
        activeCycles   = 0;
        waitCycles     = 0;
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        reset = 1'b0;
        @(negedge clk);
        checkIdleOutputs();

        for (int c = 0; c < 500; c++) begin  // nothing may start while disabled.
            @(negedge clk);
            if (spiCsLow) begin
                activeCycles++;
            end
        end
        if (activeCycles != 0) begin
            protocolErrors++;
            $display("chip select was active for %0d cycles with i_enable low", activeCycles);
        end

        @(negedge clk);
        enable = 1'b1;
        while (sensor0.writeCount < 3) begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > 3000) begin
                abortOnTimeout("the three start-up writes did not arrive");
            end
        end
        compareField("start-up write 1", 36'h1F52, 36'(sensor0.writeLog[0]));
        compareField("start-up write 2", 36'h2D02, 36'(sensor0.writeLog[1]));
        compareField("start-up write 3", 36'h2C14, 36'(sensor0.writeLog[2]));
        for (int k = 0; k < 3; k++) begin
            compareField("start-up instruction byte", 36'h0A,
                         36'(sensor0.txnLog[k].instruction));
        end

        waitForSamples(SAMPLES_FIRST);

        pauseDelay = int'({$random(seed)} % 32'd1000);  // drop enable somewhere in a loop.
        for (int c = 0; c < pauseDelay; c++) begin
            @(posedge clk);
        end
        startsAtDrop = csStarts;
        @(negedge clk);
        enable = 1'b0;
        for (int c = 0; c < 400; c++) begin  // an accepted command may still finish.
            @(posedge clk);
        end
        if ((csStarts - startsAtDrop > 1) || spiCsLow) begin
            protocolErrors++;
            $display("after i_enable fell, %0d transactions started and chip select is %0b",
                     csStarts - startsAtDrop, spiCsLow);
        end
        startsAtDrop   = csStarts;
        samplesAtQuiet = sampleCount;
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(posedge clk);
        end
        if ((csStarts != startsAtDrop) || (sampleCount != samplesAtQuiet)) begin
            protocolErrors++;
            $display("the pause was not quiet, %0d transactions and %0d samples appeared",
                     csStarts - startsAtDrop, sampleCount - samplesAtQuiet);
        end

        @(negedge clk);
        enable = 1'b1;
        waitForSamples(sampleCount + SAMPLES_AFTER);
        compareField("start-up write count", 36'h3, 36'(sensor0.writeCount));
        finishRun();
    end

endmodule

`default_nettype wire

// File: build.f
source/adxlPkg.sv
source/spiShifter.sv
source/spiTransaction.sv
source/adxlSequencer.sv
source/adxlTop.sv
bench/adxlSensorModel.sv
bench/adxlTopBench.sv

// File: run.sh
#!/bin/sh
# Build the accelerometer driver testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module adxlTopBench -f build.f -o simBench
./obj_dir/simBench > sim.log
cat sim.log
if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0
